// ==== src.f ====
+incdir+.
axil_pkg.sv
flash_pkg.sv
spi_slave_shifter.sv
flash_read_engine.sv
axil_host_port.sv
image_mem_arbiter.sv
cmd_log_fifo.sv
spiemu_top.sv
spiemu_chk.sv
tb_spiemu.sv

// ==== tb_spiemu.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench for the SPI flash emulator, AXI4-Lite host and SPI mode 0 master
// inputs change on the falling clk edge, SCK half period is 6 clk cycles
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`default_nettype none
`include "spiemu_consts.svh"

module tb_spiemu;
	localparam int IMG_SIZE = 1 << `SPIEMU_IMG_ADDR_BITS;
	localparam int AXI_TIMEOUT = 2000;
	localparam int SCK_HALF = 6;

	logic clk;
	logic reset;
	logic sck;
	logic cs_n;
	logic mosi;
	logic miso;
	axil_pkg::axil_req_t axil_req;
	axil_pkg::axil_rsp_t axil_rsp;

	// expected image contents
	logic [7:0] image [0:IMG_SIZE-1];
	// bytes sent and received on the last SPI transfer
	logic [7:0] spi_tx [0:31];
	logic [7:0] spi_rx [0:31];
	// expected log contents and overflow flag
	logic [31:0] log_model [$];
	logic log_ovf;
	int checks;
	int errors;
	int test_mark;
	int chk_seen;

	spiemu_top spiemu_i (
		.clk(clk),
		.reset(reset),
		.sck(sck),
		.cs_n(cs_n),
		.mosi(mosi),
		.miso(miso),
		.axil_req(axil_req),
		.axil_rsp(axil_rsp)
	);

	always #50 clk = ~clk;

	task automatic expect_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		assert (got === exp)
		else begin
			$display("FAIL %s got %h expected %h", name, got, exp);
			errors++;
		end
	endtask

	task automatic expect_true(input logic cond, input string what);
		checks++;
		assert (cond === 1'b1)
		else begin
			$display("FAIL %s", what);
			errors++;
		end
	endtask

	task automatic abort_timeout(input string what);
		$display("timeout while waiting for %s", what);
		$display("Errors found");
		$finish;
	endtask

	task automatic report_test(input string name);
		// failures of the bound protocol assertions count as well
		errors += spiemu_i.chk_i.fail_count - chk_seen;
		chk_seen = spiemu_i.chk_i.fail_count;
		$display("test %s done, %0d errors", name, errors - test_mark);
		test_mark = errors;
	endtask

	task automatic axil_write(input logic [31:0] addr, input logic [31:0] data,
			output logic [1:0] resp);
		int n;
		@(negedge clk);
		axil_req.awaddr = addr;
		axil_req.awvalid = 1'b1;
		axil_req.wdata = data;
		axil_req.wstrb = 4'hf;
		axil_req.wvalid = 1'b1;
		axil_req.bready = 1'b0;
		n = 0;
		// awready is combinational, look just after the inputs settle
		#1;
		while (!axil_rsp.awready) begin
			@(negedge clk);
			#1;
			n++;
			if (n > AXI_TIMEOUT)
				abort_timeout("write address and data accept");
		end
		@(negedge clk);
		axil_req.awvalid = 1'b0;
		axil_req.wvalid = 1'b0;
		n = 0;
		while (!axil_rsp.bvalid) begin
			@(negedge clk);
			n++;
			if (n > AXI_TIMEOUT)
				abort_timeout("write response");
		end
		// bready held low for a cycle, the response has to stay put
		@(negedge clk);
		resp = axil_rsp.bresp;
		axil_req.bready = 1'b1;
		@(negedge clk);
		axil_req.bready = 1'b0;
	endtask

	task automatic axil_read(input logic [31:0] addr, output logic [31:0] data,
			output logic [1:0] resp);
		int n;
		@(negedge clk);
		axil_req.araddr = addr;
		axil_req.arvalid = 1'b1;
		axil_req.rready = 1'b0;
		n = 0;
		#1;
		while (!axil_rsp.arready) begin
			@(negedge clk);
			#1;
			n++;
			if (n > AXI_TIMEOUT)
				abort_timeout("read address accept");
		end
		@(negedge clk);
		axil_req.arvalid = 1'b0;
		n = 0;
		while (!axil_rsp.rvalid) begin
			@(negedge clk);
			n++;
			if (n > AXI_TIMEOUT)
				abort_timeout("read data");
		end
		// rready held low for a cycle, the data has to stay put
		@(negedge clk);
		data = axil_rsp.rdata;
		resp = axil_rsp.rresp;
		axil_req.rready = 1'b1;
		@(negedge clk);
		axil_req.rready = 1'b0;
	endtask

	task automatic write_reg(input logic [31:0] addr, input logic [31:0] data);
		logic [1:0] resp;
		axil_write(addr, data, resp);
		expect_eq("bresp", {30'h0, resp}, 32'h0);
	endtask

	task automatic read_reg(input logic [31:0] addr, input string name, input logic [31:0] exp);
		logic [31:0] data;
		logic [1:0] resp;
		axil_read(addr, data, resp);
		expect_eq("rresp", {30'h0, resp}, 32'h0);
		expect_eq(name, data, exp);
	endtask

	// mode 0 master, miso taken at the end of each low phase
	task automatic spi_xfer(input int n);
		int i;
		int b;
		@(negedge clk);
		cs_n = 1'b0;
		for (i = 0; i < n; i++) begin
			for (b = 7; b >= 0; b--) begin
				mosi = spi_tx[i][b];
				repeat (SCK_HALF) @(negedge clk);
				spi_rx[i][b] = miso;
				sck = 1'b1;
				repeat (SCK_HALF) @(negedge clk);
				sck = 1'b0;
			end
		end
		repeat (SCK_HALF) @(negedge clk);
		cs_n = 1'b1;
		mosi = 1'b0;
		// let the select window close before the next access
		repeat (SCK_HALF) @(negedge clk);
	endtask

	// header then ndata dummy bytes, model logs any nonzero header
	task automatic spi_cmd(input logic [7:0] op, input logic [23:0] addr, input int ndata);
		int i;
		spi_tx[0] = op;
		spi_tx[1] = addr[23:16];
		spi_tx[2] = addr[15:8];
		spi_tx[3] = addr[7:0];
		for (i = 4; i < 4 + ndata; i++)
			spi_tx[i] = 8'hff;
		spi_xfer(4 + ndata);
		if ({op, addr} != 32'h0) begin
			if (log_model.size() < `SPIEMU_LOG_DEPTH)
				log_model.push_back({op, addr});
			else
				log_ovf = 1'b1;
		end
	endtask

	// status read clears overflow in the model as well
	task automatic check_log_stat();
		read_reg(`SPIEMU_REG_LOG_STAT, "log_stat",
			{27'd0, log_ovf, 4'(log_model.size())});
		log_ovf = 1'b0;
	endtask

	task automatic drain_log();
		logic [31:0] exp;
		check_log_stat();
		while (log_model.size() > 0) begin
			exp = log_model.pop_front();
			read_reg(`SPIEMU_REG_LOG_DATA, "log_data", exp);
		end
		check_log_stat();
	endtask

	initial begin
		int i;
		int k;
		logic [31:0] data;
		logic [31:0] addr;
		logic [1:0] resp;
		logic [23:0] a24;
		logic [7:0] wbyte;

		void'($urandom(32'h7eec));
		checks = 0;
		errors = 0;
		test_mark = 0;
		chk_seen = 0;
		log_ovf = 1'b0;
		clk = 1'b0;
		reset = 1'b1;
		sck = 1'b0;
		cs_n = 1'b1;
		mosi = 1'b0;
		axil_req = '0;
		repeat (4) @(negedge clk);
		reset = 1'b0;

		// idle outputs and an empty log
		expect_eq("miso", {31'h0, miso}, 32'h1);
		check_log_stat();
		report_test("reset state");

		// whole image through DATA, only the low byte is stored
		write_reg(`SPIEMU_REG_PTR, 32'h0);
		for (i = 0; i < IMG_SIZE; i++) begin
			data = $urandom;
			image[i] = data[7:0];
			write_reg(`SPIEMU_REG_DATA, data);
		end
		// pointer wrapped back to zero after a full image
		read_reg(`SPIEMU_REG_PTR, "ptr", 32'h0);
		addr = $urandom % IMG_SIZE;
		write_reg(`SPIEMU_REG_PTR, addr);
		for (k = 0; k < 32; k++)
			read_reg(`SPIEMU_REG_DATA, "data", {24'h0, image[(addr + k) % IMG_SIZE]});
		read_reg(`SPIEMU_REG_PTR, "ptr", (addr + 32) % IMG_SIZE);
		report_test("image load and readback");

		// start in the last 8 bytes so 16 bytes cross the image end
		a24 = {12'($urandom), 9'h1ff, 3'($urandom)};
		spi_cmd(flash_pkg::OP_READ, a24, 16);
		for (k = 0; k < 4; k++)
			expect_eq("miso header byte", {24'h0, spi_rx[k]}, 32'hff);
		for (k = 0; k < 16; k++)
			expect_eq("miso data byte", {24'h0, spi_rx[4 + k]},
				{24'h0, image[(a24[11:0] + k) % IMG_SIZE]});
		report_test("spi read with wrap");

		// host DATA write issued in the middle of a SPI read
		addr = $urandom % IMG_SIZE;
		wbyte = $urandom;
		a24 = 24'($urandom);
		write_reg(`SPIEMU_REG_PTR, addr);
		fork
			spi_cmd(flash_pkg::OP_READ, a24, 4);
			begin
				repeat (20) @(negedge clk);
				axil_write(`SPIEMU_REG_DATA, {24'h0, wbyte}, resp);
				expect_eq("bresp", {30'h0, resp}, 32'h0);
				expect_true(cs_n, "DATA write completed while CS was low");
			end
		join
		// RAM is written after CS rises, so the read saw the old bytes
		for (k = 0; k < 4; k++)
			expect_eq("miso data byte", {24'h0, spi_rx[4 + k]},
				{24'h0, image[(a24[11:0] + k) % IMG_SIZE]});
		image[addr] = wbyte;
		write_reg(`SPIEMU_REG_PTR, addr);
		read_reg(`SPIEMU_REG_DATA, "data", {24'h0, wbyte});
		report_test("host write during chip select");

		// headers of the earlier reads come out in order
		drain_log();
		// an all zero header is not logged
		spi_cmd(8'h00, 24'h0, 0);
		check_log_stat();
		// nine commands into eight entries
		for (i = 0; i < 9; i++)
			spi_cmd(8'h40 | 8'($urandom), 24'($urandom), 0);
		check_log_stat();
		check_log_stat();
		drain_log();
		// empty log reads as zero
		read_reg(`SPIEMU_REG_LOG_DATA, "log_data", 32'h0);
		report_test("command log and overflow");

		// unmapped offset
		axil_read(32'h10, data, resp);
		expect_eq("rresp", {30'h0, resp}, {30'h0, axil_pkg::RESP_SLVERR});
		expect_eq("rdata", data, 32'h0);
		axil_write(32'h10, 32'h5a, resp);
		expect_eq("bresp", {30'h0, resp}, {30'h0, axil_pkg::RESP_SLVERR});
		// fast read opcode is not served
		spi_cmd(8'h0b, 24'($urandom), 4);
		for (k = 0; k < 8; k++)
			expect_eq("miso byte", {24'h0, spi_rx[k]}, 32'hff);
		drain_log();
		report_test("unmapped offset and other opcode");

		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

endmodule

`default_nettype wire

// ==== spiemu_chk.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// AXI4-Lite response and image RAM grant checks, bound into spiemu_top
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`default_nettype none

module spiemu_chk (
	input logic clk,
	input logic reset,
	input logic cs_n,
	input axil_pkg::axil_req_t axil_req,
	input axil_pkg::axil_rsp_t axil_rsp,
	input logic spi_grant,
	input logic host_grant
);
	// assertion failures so far, read by the testbench
	int fail_count = 0;

	// write response held with the same code until bready
	b_hold: assert property (@(posedge clk) disable iff (reset)
		axil_rsp.bvalid && !axil_req.bready |=> axil_rsp.bvalid && $stable(axil_rsp.bresp))
		else begin
			$error("bvalid dropped or bresp changed before bready");
			fail_count++;
		end

	// read data held until rready
	r_hold: assert property (@(posedge clk) disable iff (reset)
		axil_rsp.rvalid && !axil_req.rready |=> axil_rsp.rvalid && $stable(axil_rsp.rdata))
		else begin
			$error("rvalid dropped or rdata changed before rready");
			fail_count++;
		end

	// one owner of the RAM at a time
	grant_excl: assert property (@(posedge clk) disable iff (reset)
		!(spi_grant && host_grant))
		else begin
			$error("spi_grant and host_grant high together");
			fail_count++;
		end

	// host kept off once the CS pin has been low through the synchronizer
	host_off: assert property (@(posedge clk) disable iff (reset)
		!cs_n && !$past(cs_n) && !$past(cs_n, 2) |-> !host_grant)
		else begin
			$error("host_grant high while CS low");
			fail_count++;
		end

	// responses and grants idle out of reset
	reset_idle: assert property (@(posedge clk)
		reset |=> !axil_rsp.bvalid && !axil_rsp.rvalid && !spi_grant && !host_grant)
		else begin
			$error("valid or grant high after reset");
			fail_count++;
		end

endmodule

bind spiemu_top spiemu_chk chk_i (
	.clk(clk),
	.reset(reset),
	.cs_n(cs_n),
	.axil_req(axil_req),
	.axil_rsp(axil_rsp),
	.spi_grant(spi_grant),
	.host_grant(host_grant)
);

`default_nettype wire

// ==== spiemu_top.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// SPI flash emulator, image loaded and log drained over AXI4-Lite
// SPI pins are sampled in clk, SCK phases at least 4 clk cycles each
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`default_nettype none

module spiemu_top (
	input logic clk,
	input logic reset,
	input logic sck,
	input logic cs_n,
	input logic mosi,
	output logic miso,
	input axil_pkg::axil_req_t axil_req,
	output axil_pkg::axil_rsp_t axil_rsp
);
	// SPI byte stream
	logic selected;
	logic rx_strobe;
	logic [7:0] rx_byte;
	logic rx_first;
	logic [7:0] tx_byte;
	// image RAM
	flash_pkg::mem_req_t spi_req;
	flash_pkg::mem_req_t host_req;
	logic spi_grant;
	logic host_grant;
	logic [7:0] mem_rdata;
	// command log
	logic log_push;
	flash_pkg::cmd_header_u log_word;
	logic log_pop;
	logic log_clear;
	logic [31:0] log_head;
	flash_pkg::log_status_t log_stat;

	spi_slave_shifter shifter_i (
		.clk(clk),
		.reset(reset),
		.sck(sck),
		.cs_n(cs_n),
		.mosi(mosi),
		.miso(miso),
		.selected(selected),
		.rx_strobe(rx_strobe),
		.rx_byte(rx_byte),
		.rx_first(rx_first),
		.tx_byte(tx_byte)
	);

	flash_read_engine engine_i (
		.clk(clk),
		.reset(reset),
		.selected(selected),
		.rx_strobe(rx_strobe),
		.rx_byte(rx_byte),
		.rx_first(rx_first),
		.tx_byte(tx_byte),
		.mem_req(spi_req),
		.mem_grant(spi_grant),
		.mem_rdata(mem_rdata),
		.log_push(log_push),
		.log_word(log_word)
	);

	axil_host_port host_i (
		.clk(clk),
		.reset(reset),
		.axil_req(axil_req),
		.axil_rsp(axil_rsp),
		.mem_req(host_req),
		.mem_grant(host_grant),
		.mem_rdata(mem_rdata),
		.log_pop(log_pop),
		.log_clear(log_clear),
		.log_head(log_head),
		.log_stat(log_stat)
	);

	// selected gates the host off the RAM for the SPI window
	image_mem_arbiter arbiter_i (
		.clk(clk),
		.reset(reset),
		.selected(selected),
		.spi_req(spi_req),
		.host_req(host_req),
		.spi_grant(spi_grant),
		.host_grant(host_grant),
		.rdata(mem_rdata)
	);

	cmd_log_fifo log_i (
		.clk(clk),
		.reset(reset),
		.push(log_push),
		.push_word(log_word),
		.pop(log_pop),
		.head(log_head),
		.status(log_stat),
		.clear_overflow(log_clear)
	);

endmodule

`default_nettype wire

// ==== cmd_log_fifo.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// command header log, a push while full is dropped and flags overflow
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`default_nettype none
`include "spiemu_consts.svh"

module cmd_log_fifo (
	input logic clk,
	input logic reset,
	input logic push,
	input flash_pkg::cmd_header_u push_word,
	input logic pop,
	output logic [31:0] head,
	output flash_pkg::log_status_t status,
	input logic clear_overflow
);
	logic [31:0] mem [0:`SPIEMU_LOG_DEPTH-1];
	logic [`SPIEMU_LOG_PTR_BITS-1:0] wr_ptr;
	logic [`SPIEMU_LOG_PTR_BITS-1:0] rd_ptr;
	logic [3:0] count;
	logic overflow;
	logic do_push;
	logic do_pop;

	assign do_push = push && count != `SPIEMU_LOG_DEPTH;
	assign do_pop = pop && count != 4'd0;

	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= 4'd0;
			overflow <= 1'b0;
		end else begin
			if (do_push)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= rd_ptr + 1'b1;
			count <= count + {3'd0, do_push} - {3'd0, do_pop};
			// a dropped entry wins over a clear in the same cycle
			if (push && !do_push)
				overflow <= 1'b1;
			else if (clear_overflow)
				overflow <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (do_push)
			mem[wr_ptr] <= push_word;
	end

	assign head = mem[rd_ptr];
	assign status = '{zero: 27'd0, overflow: overflow, count: count};

endmodule

`default_nettype wire

// ==== image_mem_arbiter.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// single port byte RAM for the flash image, SPI owns it during CS low
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`default_nettype none
`include "spiemu_consts.svh"

module image_mem_arbiter (
	input logic clk,
	input logic reset,
	input logic selected,
	input flash_pkg::mem_req_t spi_req,
	input flash_pkg::mem_req_t host_req,
	output logic spi_grant,
	output logic host_grant,
	output logic [7:0] rdata
);
	logic [7:0] mem [0:(1 << `SPIEMU_IMG_ADDR_BITS) - 1];
	// high for one cycle past the select window
	logic spi_window;
	logic [`SPIEMU_IMG_ADDR_BITS-1:0] rd_addr;

	// the whole chip select window belongs to the SPI side
	assign spi_grant = selected & spi_req.valid;
	// host waits until the window has fully closed
	assign host_grant = ~selected & ~spi_window & host_req.valid;

	assign rd_addr = selected ? spi_req.addr : host_req.addr;

	always_ff @(posedge clk) begin
		if (reset)
			spi_window <= 1'b0;
		else
			spi_window <= selected;
	end

	// only the host writes, SPI requests are reads
	always_ff @(posedge clk) begin
		if (host_grant && host_req.write)
			mem[host_req.addr] <= host_req.wdata;
	end

	// read data valid the cycle after the grant, shared by both sides
	always_ff @(posedge clk) begin
		if (spi_grant || host_grant)
			rdata <= mem[rd_addr];
	end

endmodule

`default_nettype wire

// ==== axil_host_port.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// AXI4-Lite slave, one transaction at a time, wstrb is not decoded
// DATA accesses wait for the image RAM, which is held off while CS is low
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`default_nettype none
`include "spiemu_consts.svh"

module axil_host_port (
	input logic clk,
	input logic reset,
	input axil_pkg::axil_req_t axil_req,
	output axil_pkg::axil_rsp_t axil_rsp,
	output flash_pkg::mem_req_t mem_req,
	input logic mem_grant,
	input logic [7:0] mem_rdata,
	output logic log_pop,
	output logic log_clear,
	input logic [31:0] log_head,
	input flash_pkg::log_status_t log_stat
);
	logic [`SPIEMU_IMG_ADDR_BITS-1:0] ptr;
	logic req_valid;
	logic req_write;
	logic [7:0] req_wdata;
	logic rd_wait;
	logic idle;
	logic wr_accept;
	logic rd_accept;
	logic bvalid;
	logic rvalid;
	axil_pkg::axil_resp_e bresp;
	axil_pkg::axil_resp_e rresp;
	logic [31:0] rdata;

	// nothing in flight and no response waiting
	assign idle = !req_valid && !rd_wait && !bvalid && !rvalid;
	// address and data are taken in the same cycle, writes first
	assign wr_accept = idle && axil_req.awvalid && axil_req.wvalid;
	assign rd_accept = idle && axil_req.arvalid && !wr_accept;

	always_ff @(posedge clk) begin
		if (reset) begin
			ptr <= '0;
			req_valid <= 1'b0;
			rd_wait <= 1'b0;
			bvalid <= 1'b0;
			rvalid <= 1'b0;
			log_pop <= 1'b0;
			log_clear <= 1'b0;
		end else begin
			log_pop <= 1'b0;
			log_clear <= 1'b0;
			rd_wait <= 1'b0;
			if (bvalid && axil_req.bready)
				bvalid <= 1'b0;
			if (rvalid && axil_req.rready)
				rvalid <= 1'b0;
			if (wr_accept) begin
				if (axil_req.awaddr == `SPIEMU_REG_PTR)
					ptr <= axil_req.wdata[`SPIEMU_IMG_ADDR_BITS-1:0];
				if (axil_req.awaddr == `SPIEMU_REG_DATA)
					req_valid <= 1'b1;
				else
					bvalid <= 1'b1;
			end
			if (rd_accept) begin
				case (axil_req.araddr)
					`SPIEMU_REG_DATA: req_valid <= 1'b1;
					`SPIEMU_REG_LOG_STAT: begin
						rvalid <= 1'b1;
						log_clear <= 1'b1;
					end
					`SPIEMU_REG_LOG_DATA: begin
						rvalid <= 1'b1;
						log_pop <= log_stat.count != 4'd0;
					end
					default: rvalid <= 1'b1;
				endcase
			end
			// DATA access granted, pointer steps on either direction
			if (req_valid && mem_grant) begin
				req_valid <= 1'b0;
				ptr <= ptr + 1'b1;
				if (req_write)
					bvalid <= 1'b1;
				else
					rd_wait <= 1'b1;
			end
			if (rd_wait)
				rvalid <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (wr_accept) begin
			req_write <= 1'b1;
			req_wdata <= axil_req.wdata[7:0];
			// log registers ignore writes, anything past them is unmapped
			if (axil_req.awaddr <= `SPIEMU_REG_LOG_DATA && axil_req.awaddr[1:0] == 2'b00)
				bresp <= axil_pkg::RESP_OKAY;
			else
				bresp <= axil_pkg::RESP_SLVERR;
		end
		if (rd_accept) begin
			req_write <= 1'b0;
			rresp <= axil_pkg::RESP_OKAY;
			case (axil_req.araddr)
				`SPIEMU_REG_PTR: rdata <= {{(32 - `SPIEMU_IMG_ADDR_BITS){1'b0}}, ptr};
				`SPIEMU_REG_DATA: rdata <= 32'h0;
				`SPIEMU_REG_LOG_STAT: rdata <= log_stat;
				`SPIEMU_REG_LOG_DATA: rdata <= (log_stat.count != 4'd0) ? log_head : 32'h0;
				default: begin
					rdata <= 32'h0;
					rresp <= axil_pkg::RESP_SLVERR;
				end
			endcase
		end
		if (rd_wait)
			rdata <= {24'h0, mem_rdata};
	end

	always_comb begin
		axil_rsp.awready = wr_accept;
		axil_rsp.wready = wr_accept;
		axil_rsp.bresp = bresp;
		axil_rsp.bvalid = bvalid;
		axil_rsp.arready = rd_accept;
		axil_rsp.rdata = rdata;
		axil_rsp.rresp = rresp;
		axil_rsp.rvalid = rvalid;
		mem_req.valid = req_valid;
		mem_req.write = req_write;
		mem_req.addr = ptr;
		mem_req.wdata = req_wdata;
	end

endmodule

`default_nettype wire

// ==== flash_read_engine.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// serves opcode 0x03 from the image, other opcodes return 0xff bytes
// expects the memory grant whenever selected and data one cycle later
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`default_nettype none
`include "spiemu_consts.svh"

module flash_read_engine (
	input logic clk,
	input logic reset,
	input logic selected,
	input logic rx_strobe,
	input logic [7:0] rx_byte,
	input logic rx_first,
	output logic [7:0] tx_byte,
	output flash_pkg::mem_req_t mem_req,
	input logic mem_grant,
	input logic [7:0] mem_rdata,
	output logic log_push,
	output flash_pkg::cmd_header_u log_word
);
	// header position of the next byte, 4 once the header is complete
	logic [2:0] byte_cnt;
	logic [2:0] hdr_idx;
	logic is_read;
	logic req_valid;
	logic rd_pending;
	logic [`SPIEMU_IMG_ADDR_BITS-1:0] rd_addr;
	flash_pkg::cmd_header_u hdr;
	flash_pkg::cmd_header_u hdr_next;

	// the first byte after select always starts a new header
	assign hdr_idx = rx_first ? 3'd0 : byte_cnt;

	// header with the received byte dropped into its slot
	always_comb begin
		hdr_next = hdr;
		hdr_next.bytes[hdr_idx[1:0]] = rx_byte;
	end

	always_ff @(posedge clk) begin
		if (reset || !selected) begin
			byte_cnt <= 3'd0;
			is_read <= 1'b0;
			req_valid <= 1'b0;
			rd_pending <= 1'b0;
			log_push <= 1'b0;
			// idle bytes and header bytes read as 0xff
			tx_byte <= 8'hff;
		end else begin
			log_push <= 1'b0;
			rd_pending <= req_valid && mem_grant;
			if (req_valid && mem_grant)
				req_valid <= 1'b0;
			// RAM data lands one cycle after the grant
			if (rd_pending)
				tx_byte <= mem_rdata;
			if (rx_strobe) begin
				if (hdr_idx != 3'd4)
					byte_cnt <= hdr_idx + 3'd1;
				if (hdr_idx == 3'd0)
					is_read <= hdr_next.cmd.opcode == flash_pkg::OP_READ;
				// last address byte, log the header and fetch data byte 0
				if (hdr_idx == 3'd3) begin
					log_push <= hdr_next != '0;
					req_valid <= is_read;
				end
				// each data byte clocked out prefetches the following one
				if (hdr_idx == 3'd4)
					req_valid <= is_read;
			end
		end
	end

	// header and read address, address wraps at the image end
	always_ff @(posedge clk) begin
		if (rx_strobe && hdr_idx != 3'd4)
			hdr <= hdr_next;
		if (rx_strobe && hdr_idx == 3'd3)
			rd_addr <= hdr_next.cmd.addr[`SPIEMU_IMG_ADDR_BITS-1:0];
		else if (rx_strobe && hdr_idx == 3'd4)
			rd_addr <= rd_addr + 1'b1;
	end

	// log_push is high the cycle after hdr took its last byte
	assign log_word = hdr;

	always_comb begin
		mem_req.valid = req_valid;
		mem_req.write = 1'b0;
		mem_req.addr = rd_addr;
		mem_req.wdata = 8'h00;
	end

endmodule

`default_nettype wire

// ==== spi_slave_shifter.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// SPI mode 0 slave sampled in the clk domain
// SCK high and low phases must each last at least 4 clk cycles
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`default_nettype none

module spi_slave_shifter (
	input logic clk,
	input logic reset,
	input logic sck,
	input logic cs_n,
	input logic mosi,
	output logic miso,
	output logic selected,
	output logic rx_strobe,
	output logic [7:0] rx_byte,
	output logic rx_first,
	input logic [7:0] tx_byte
);
	// two flops per pin, third sck stage for edge detect
	logic [2:0] sck_sync;
	logic [1:0] cs_sync;
	logic [1:0] mosi_sync;
	logic sck_rise;
	logic sck_fall;
	logic [2:0] bit_cnt;
	logic [6:0] rx_shift;
	logic [7:0] tx_shift;
	logic first_pending;

	assign selected = ~cs_sync[1];
	assign sck_rise = sck_sync[1] & ~sck_sync[2];
	assign sck_fall = ~sck_sync[1] & sck_sync[2];

	always_ff @(posedge clk) begin
		if (reset) begin
			sck_sync <= '0;
			cs_sync <= '1;
			mosi_sync <= '0;
		end else begin
			sck_sync <= {sck_sync[1:0], sck};
			cs_sync <= {cs_sync[0], cs_n};
			mosi_sync <= {mosi_sync[0], mosi};
		end
	end

	// bit framing restarts whenever chip select is released
	always_ff @(posedge clk) begin
		if (reset || !selected) begin
			bit_cnt <= 3'd0;
			first_pending <= 1'b1;
			rx_strobe <= 1'b0;
			rx_first <= 1'b0;
			tx_shift <= 8'hff;
			miso <= 1'b1;
		end else begin
			rx_strobe <= 1'b0;
			if (sck_rise) begin
				bit_cnt <= bit_cnt + 3'd1;
				if (bit_cnt == 3'd7) begin
					rx_strobe <= 1'b1;
					rx_first <= first_pending;
					first_pending <= 1'b0;
				end
			end
			// byte boundary, msb of the next byte goes out right away
			if (sck_fall) begin
				if (bit_cnt == 3'd0) begin
					miso <= tx_byte[7];
					tx_shift <= {tx_byte[6:0], 1'b1};
				end else begin
					miso <= tx_shift[7];
					tx_shift <= {tx_shift[6:0], 1'b1};
				end
			end
		end
	end

	// mosi is aligned with sck_sync[1]
	always_ff @(posedge clk) begin
		if (sck_rise) begin
			rx_shift <= {rx_shift[5:0], mosi_sync[1]};
			if (bit_cnt == 3'd7)
				rx_byte <= {rx_shift, mosi_sync[1]};
		end
	end

endmodule

`default_nettype wire

// ==== flash_pkg.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// flash command, image memory request and command log types
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none
`include "spiemu_consts.svh"

package flash_pkg;

	// only the plain read is served, anything else is just logged
	typedef enum logic [7:0] {
		OP_READ = 8'h03
	} flash_opcode_e;

	// opcode in the top byte, address msb first behind it
	typedef struct packed {
		flash_opcode_e opcode;
		logic [23:0] addr;
	} cmd_fields_t;

	// one header word seen either as fields or as wire bytes
	// bytes[0] is the first byte on the wire and sits in bits 31:24
	typedef union packed {
		cmd_fields_t cmd;
		logic [0:3][7:0] bytes;
	} cmd_header_u;

	// single byte access to the image RAM
	typedef struct packed {
		logic valid;
		logic write;
		logic [`SPIEMU_IMG_ADDR_BITS-1:0] addr;
		logic [7:0] wdata;
	} mem_req_t;

	// log status word as seen by the host
	typedef struct packed {
		logic [26:0] zero;
		logic overflow;
		logic [3:0] count;
	} log_status_t;

endpackage

`default_nettype wire

// ==== axil_pkg.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// AXI4-Lite channel bundles, 32 bit address and data, no prot signals
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package axil_pkg;

	// response codes
	typedef enum logic [1:0] {
		RESP_OKAY = 2'b00,
		RESP_EXOKAY = 2'b01,
		RESP_SLVERR = 2'b10,
		RESP_DECERR = 2'b11
	} axil_resp_e;

	// master to slave
	typedef struct packed {
		logic [31:0] awaddr;
		logic awvalid;
		logic [31:0] wdata;
		logic [3:0] wstrb;
		logic wvalid;
		logic bready;
		logic [31:0] araddr;
		logic arvalid;
		logic rready;
	} axil_req_t;

	// slave to master
	typedef struct packed {
		logic awready;
		logic wready;
		axil_resp_e bresp;
		logic bvalid;
		logic arready;
		logic [31:0] rdata;
		axil_resp_e rresp;
		logic rvalid;
	} axil_rsp_t;

endpackage

`default_nettype wire

// ==== spiemu_consts.svh ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// sizes and register map for the SPI flash emulator
// image size must be a power of two, SPI and host addresses wrap within it
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef SPIEMU_CONSTS_SVH
`define SPIEMU_CONSTS_SVH

// 4 KiB image
`define SPIEMU_IMG_ADDR_BITS 12

// command log, depth must be a power of two and fit a 4 bit count
`define SPIEMU_LOG_DEPTH 8
`define SPIEMU_LOG_PTR_BITS 3

// AXI4-Lite register offsets
`define SPIEMU_REG_PTR 32'h0
`define SPIEMU_REG_DATA 32'h4
`define SPIEMU_REG_LOG_STAT 32'h8
`define SPIEMU_REG_LOG_DATA 32'hc

`endif
